/* files.f */
hdl/clk_rst_pkg.sv
hdl/axil_cfg_bridge.sv
hdl/clk_csr.sv
hdl/lock_monitor.sv
hdl/rst_ctrl.sv
hdl/clk_ctrl_top.sv
testbench/tb_clk_ctrl_top.sv

/* hdl/axil_cfg_bridge.sv */
// ====================================================================
// AXI-Lite slave to configuration bus bridge
// One transaction at a time with writes ahead of reads
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module axil_cfg_bridge (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   // Write channels
   input  logic [31:0]            i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  clk_rst_pkg::csr_data_t i_wdata,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output clk_rst_pkg::axi_resp_t o_bresp,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   // Read channels
   input  logic [31:0]            i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output clk_rst_pkg::csr_data_t o_rdata,
   output clk_rst_pkg::axi_resp_t o_rresp,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   // Config bus
   output clk_rst_pkg::cfg_req_t  o_cfg_req,
   input  clk_rst_pkg::cfg_rsp_t  i_cfg_rsp
);
   import clk_rst_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      WR_RESP,
      RD_RESP
   } state_t;

   state_t    state_q;
   logic      wr_go;           // AW and W accepted together
   logic      rd_go;
   logic      req_valid_q;
   logic      req_write_q;
   csr_addr_t req_addr_q;
   csr_data_t req_wdata_q;
   csr_data_t rdata_q;
   logic      err_q;
   axi_resp_t resp;

   // ==================================================================
   // Accept
   // ==================================================================
   assign wr_go = (state_q == IDLE) && i_awvalid && i_wvalid;
   assign rd_go = (state_q == IDLE) && i_arvalid && !(i_awvalid && i_wvalid); // Write first

   assign o_awready = wr_go;
   assign o_wready  = wr_go;
   assign o_arready = rd_go;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_q     <= IDLE;
         req_valid_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (wr_go || rd_go) begin
                  state_q     <= REQ;
                  req_valid_q <= 1'b1;       // Request from next cycle
               end
            end
            REQ: begin
               if (i_cfg_rsp.ack) begin      // Drop request on ack
                  req_valid_q <= 1'b0;
                  state_q     <= req_write_q ? WR_RESP : RD_RESP;
               end
            end
            WR_RESP: if (i_bready) state_q <= IDLE;
            RD_RESP: if (i_rready) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Payload capture
   always_ff @(posedge i_clk) begin
      if (wr_go) begin
         req_write_q <= 1'b1;
         req_addr_q  <= i_awaddr[CSR_ADDR_W-1:0];   // Word address only
         req_wdata_q <= i_wdata;
      end else if (rd_go) begin
         req_write_q <= 1'b0;
         req_addr_q  <= i_araddr[CSR_ADDR_W-1:0];
      end
      if ((state_q == REQ) && i_cfg_rsp.ack) begin
         rdata_q <= i_cfg_rsp.rdata;
         err_q   <= i_cfg_rsp.err;
      end
   end

   assign o_cfg_req = '{valid: req_valid_q, write: req_write_q,
                        addr: req_addr_q, wdata: req_wdata_q};

   // ==================================================================
   // Response
   // ==================================================================
   assign resp     = err_q ? RESP_SLVERR : RESP_OKAY;
   assign o_bvalid = (state_q == WR_RESP);       // Held until bready
   assign o_bresp  = resp;
   assign o_rvalid = (state_q == RD_RESP);       // Held until rready
   assign o_rresp  = resp;
   assign o_rdata  = rdata_q;

endmodule

`default_nettype wire

/* hdl/clk_csr.sv */
// ====================================================================
// Clock and reset register file
// Request edge detect, address decode, read mux
// Control registers, sticky lock loss and reset control output
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module clk_csr (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  clk_rst_pkg::cfg_req_t   i_cfg_req,
   output clk_rst_pkg::cfg_rsp_t   o_cfg_rsp,
   input  clk_rst_pkg::lock_stat_t i_lock_stat,
   output clk_rst_pkg::rst_ctl_t   o_rst_ctl
);
   import clk_rst_pkg::*;

   // Request stage
   logic      valid_q;
   logic      pulse_q;          // First cycle of a request
   logic      write_q;
   csr_addr_t addr_q;
   csr_data_t wdata_q;
   logic      ack_q;
   csr_data_t rdata_q;
   logic      err_q;

   // Register state kept through i_rst_n
   csr_data_t g_rst_q        = '0;
   csr_data_t sys_rst_q      = SYS_RST_INIT;
   logic      dis_rst_main_q = 1'b0;
   csr_data_t lock_err_q     = '0;
   rst_ctl_t  rst_ctl_q      = '{glbl_rst: 1'b0,
                                 sys_rst: SYS_RST_INIT[NUM_RST-1:0],
                                 dis_rst_main: 1'b0};

   csr_data_t clks_avail;
   csr_data_t lock_word;
   csr_data_t lost_word;
   csr_data_t rd_word;
   csr_data_t w1c_mask;
   logic      bad_addr;
   logic      wr_en;

   // ==================================================================
   // Request edge and ack
   // ==================================================================
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
         pulse_q <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         valid_q <= i_cfg_req.valid;
         pulse_q <= i_cfg_req.valid & ~valid_q;  // Rising edge
         ack_q   <= pulse_q;                      // Second cycle
      end
   end

   always_ff @(posedge i_clk) begin
      write_q <= i_cfg_req.write;
      addr_q  <= i_cfg_req.addr;
      wdata_q <= i_cfg_req.wdata;
   end

   // ==================================================================
   // Status words
   // ==================================================================
   assign clks_avail = {{(CSR_DATA_W-NUM_RST){1'b0}},
                        HBM_EN, HBM_EN,                // HBM ref, axi
                        GRP_C_EN, GRP_C_EN,
                        GRP_B_EN, GRP_B_EN,
                        GRP_A_EN, GRP_A_EN, GRP_A_EN,
                        1'b1};                         // Main always there

   always_comb begin
      lock_word               = '0;
      lock_word[LOCK_POS_A]   = i_lock_stat.locked[0];
      lock_word[LOCK_POS_B]   = i_lock_stat.locked[1];
      lock_word[LOCK_POS_C]   = i_lock_stat.locked[2];
      lock_word[LOCK_POS_HBM] = i_lock_stat.locked[3];
      lost_word               = '0;
      lost_word[LOCK_POS_A]   = i_lock_stat.lost[0];
      lost_word[LOCK_POS_B]   = i_lock_stat.lost[1];
      lost_word[LOCK_POS_C]   = i_lock_stat.lost[2];
      lost_word[LOCK_POS_HBM] = i_lock_stat.lost[3];
   end

   // ==================================================================
   // Read mux
   // ==================================================================
   always_comb begin
      bad_addr = 1'b0;
      case (addr_q)
         REG_ID:           rd_word = ID_VALUE;
         REG_VER:          rd_word = VER_VALUE;
         REG_BUILD:        rd_word = BUILD_VALUE;
         REG_CLKS_AVAIL:   rd_word = clks_avail;
         REG_G_RST:        rd_word = g_rst_q;
         REG_SYS_RST:      rd_word = sys_rst_q;
         REG_DIS_RST_MAIN: rd_word = {{(CSR_DATA_W-1){1'b0}}, dis_rst_main_q};
         REG_LOCK:         rd_word = lock_word;
         REG_LOCK_ERR:     rd_word = lock_err_q;
         default: begin
            rd_word  = BAD_ADDR_DATA;
            bad_addr = 1'b1;                     // Unmapped
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (pulse_q) begin
         rdata_q <= rd_word;
         err_q   <= bad_addr;
      end
   end

   assign o_cfg_rsp = '{ack: ack_q, rdata: rdata_q, err: err_q};

   // ==================================================================
   // Writes
   // ==================================================================
   assign wr_en    = pulse_q & write_q & ~bad_addr;
   assign w1c_mask = (wr_en && (addr_q == REG_LOCK_ERR)) ? wdata_q : '0;

   always_ff @(posedge i_clk) begin
      if (wr_en && (addr_q == REG_G_RST))        g_rst_q        <= wdata_q;
      if (wr_en && (addr_q == REG_SYS_RST))      sys_rst_q      <= wdata_q;
      if (wr_en && (addr_q == REG_DIS_RST_MAIN)) dis_rst_main_q <= wdata_q[0];
      lock_err_q <= (lock_err_q & ~w1c_mask) | lost_word;  // Set beats clear
   end

   // Reset control to rst_ctrl
   always_ff @(posedge i_clk) begin
      rst_ctl_q.glbl_rst     <= (g_rst_q == '1);
      rst_ctl_q.sys_rst      <= sys_rst_q[NUM_RST-1:0];
      rst_ctl_q.dis_rst_main <= dis_rst_main_q;
   end

   assign o_rst_ctl = rst_ctl_q;

endmodule

`default_nettype wire

/* hdl/clk_ctrl_top.sv */
// ====================================================================
// Clock and reset control top level
// AXI-Lite bridge, register file, lock monitor, reset controller
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_top (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic [31:0]            i_awaddr,
   input  logic                   i_awvalid,
   output logic                   o_awready,
   input  clk_rst_pkg::csr_data_t i_wdata,
   input  logic                   i_wvalid,
   output logic                   o_wready,
   output clk_rst_pkg::axi_resp_t o_bresp,
   output logic                   o_bvalid,
   input  logic                   i_bready,
   input  logic [31:0]            i_araddr,
   input  logic                   i_arvalid,
   output logic                   o_arready,
   output clk_rst_pkg::csr_data_t o_rdata,
   output clk_rst_pkg::axi_resp_t o_rresp,
   output logic                   o_rvalid,
   input  logic                   i_rready,
   input  clk_rst_pkg::lock_vec_t i_mmcm_lock,
   output logic                   o_glbl_rst,
   output clk_rst_pkg::rst_vec_t  o_rst_n
);
   import clk_rst_pkg::*;

   cfg_req_t   cfg_req;
   cfg_rsp_t   cfg_rsp;
   lock_stat_t lock_stat;
   rst_ctl_t   rst_ctl;

   // Host side
   axil_cfg_bridge axil_cfg_bridge_inst (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_awaddr  (i_awaddr),
      .i_awvalid (i_awvalid),
      .o_awready (o_awready),
      .i_wdata   (i_wdata),
      .i_wvalid  (i_wvalid),
      .o_wready  (o_wready),
      .o_bresp   (o_bresp),
      .o_bvalid  (o_bvalid),
      .i_bready  (i_bready),
      .i_araddr  (i_araddr),
      .i_arvalid (i_arvalid),
      .o_arready (o_arready),
      .o_rdata   (o_rdata),
      .o_rresp   (o_rresp),
      .o_rvalid  (o_rvalid),
      .i_rready  (i_rready),
      .o_cfg_req (cfg_req),
      .i_cfg_rsp (cfg_rsp)
   );

   clk_csr clk_csr_inst (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_cfg_req   (cfg_req),
      .o_cfg_rsp   (cfg_rsp),
      .i_lock_stat (lock_stat),
      .o_rst_ctl   (rst_ctl)
   );

   lock_monitor lock_monitor_inst (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_mmcm_lock (i_mmcm_lock),
      .o_lock_stat (lock_stat)
   );

   // Resets use synchronized lock only
   rst_ctrl rst_ctrl_inst (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_rst_ctl  (rst_ctl),
      .i_locked   (lock_stat.locked),
      .o_glbl_rst (o_glbl_rst),
      .o_rst_n    (o_rst_n)
   );

endmodule

`default_nettype wire

/* hdl/clk_rst_pkg.sv */
// ====================================================================
// Clock and reset control package
// Register map, identification words and group enables
// Vector typedefs and configuration bus structs
// ====================================================================
`default_nettype none

package clk_rst_pkg;

   // Widths
   localparam int CSR_ADDR_W = 8;
   localparam int CSR_DATA_W = 32;
   localparam int NUM_RST    = 10;    // Main, A x3, B x2, C x2, HBM x2
   localparam int NUM_MMCM   = 4;     // A, B, C, HBM

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;
   typedef logic [NUM_RST-1:0]    rst_vec_t;
   typedef logic [NUM_MMCM-1:0]   lock_vec_t;
   typedef logic [1:0]            axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // ==================================================================
   // Register map
   // ==================================================================
   localparam csr_addr_t REG_ID           = 8'h00;
   localparam csr_addr_t REG_VER          = 8'h04;
   localparam csr_addr_t REG_BUILD        = 8'h08;
   localparam csr_addr_t REG_CLKS_AVAIL   = 8'h0C;
   localparam csr_addr_t REG_G_RST        = 8'h10;
   localparam csr_addr_t REG_SYS_RST      = 8'h14;
   localparam csr_addr_t REG_DIS_RST_MAIN = 8'h18;
   localparam csr_addr_t REG_LOCK         = 8'h20;
   localparam csr_addr_t REG_LOCK_ERR     = 8'h24;

   localparam csr_data_t ID_VALUE      = 32'h5a3c_0001;
   localparam csr_data_t VER_VALUE     = 32'h0102_0000;  // Arch, major, minor, patch
   localparam csr_data_t BUILD_VALUE   = 32'h2024_0611;
   localparam csr_data_t BAD_ADDR_DATA = 32'hdead_c0de;
   localparam csr_data_t SYS_RST_INIT  = 32'hffff_fffe;  // All but main held

   // Clock group enables
   localparam logic GRP_A_EN = 1'b1;
   localparam logic GRP_B_EN = 1'b1;
   localparam logic GRP_C_EN = 1'b1;
   localparam logic HBM_EN   = 1'b1;

   // Lock bit positions in REG_LOCK and REG_LOCK_ERR
   localparam int LOCK_POS_A   = 0;
   localparam int LOCK_POS_B   = 4;
   localparam int LOCK_POS_C   = 6;
   localparam int LOCK_POS_HBM = 8;

   // ==================================================================
   // Bus structs
   // ==================================================================
   typedef struct packed {
      logic      valid;
      logic      write;
      csr_addr_t addr;
      csr_data_t wdata;
   } cfg_req_t;

   typedef struct packed {
      logic      ack;
      csr_data_t rdata;
      logic      err;
   } cfg_rsp_t;

   typedef struct packed {
      lock_vec_t locked;
      lock_vec_t lost;         // One-cycle pulse per MMCM
   } lock_stat_t;

   typedef struct packed {
      logic     glbl_rst;
      rst_vec_t sys_rst;
      logic     dis_rst_main;
   } rst_ctl_t;

endpackage

`default_nettype wire

/* hdl/lock_monitor.sv */
// ====================================================================
// MMCM lock synchronizer and lock loss detector
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module lock_monitor (
   input  logic                    i_clk,
   input  logic                    i_rst_n,
   input  clk_rst_pkg::lock_vec_t  i_mmcm_lock,
   output clk_rst_pkg::lock_stat_t o_lock_stat
);
   import clk_rst_pkg::*;

   lock_vec_t sync1_q;
   lock_vec_t sync2_q;          // Synchronized lock
   lock_vec_t locked_d_q;       // One cycle older copy
   lock_vec_t lost_q;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         sync1_q    <= '0;        // Lock reads 0 in reset
         sync2_q    <= '0;
         locked_d_q <= '0;
         lost_q     <= '0;
      end else begin
         sync1_q    <= i_mmcm_lock;
         sync2_q    <= sync1_q;
         locked_d_q <= sync2_q;
         lost_q     <= locked_d_q & ~sync2_q;  // 1 to 0 edge
      end
   end

   assign o_lock_stat = '{locked: sync2_q, lost: lost_q};

endmodule

`default_nettype wire

/* hdl/rst_ctrl.sv */
// ====================================================================
// Domain reset generation
// Ten registered active-low resets plus global reset
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module rst_ctrl (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  clk_rst_pkg::rst_ctl_t  i_rst_ctl,
   input  clk_rst_pkg::lock_vec_t i_locked,
   output logic                   o_glbl_rst = 1'b0,
   output clk_rst_pkg::rst_vec_t  o_rst_n = '0
);
   import clk_rst_pkg::*;

   rst_vec_t grp_ok;            // Group enabled and locked
   logic     run;

   // ==================================================================
   // Reset rule per domain
   //   glbl_rst  sys_rst[k]  dis_rst_main  i_rst_n  lock   out
   //      1          x            x           x       x     0
   //      0          1            x           x       x     0
   //      0          0            0           0       x     0
   //      0          0            x           x       0     0 (k >= 1)
   //      0          0            1           x       1     1
   //      0          0            0           1       1     1
   // ==================================================================
   assign grp_ok = {{2{i_locked[3] & HBM_EN}},    // HBM
                    {2{i_locked[2] & GRP_C_EN}},
                    {2{i_locked[1] & GRP_B_EN}},
                    {3{i_locked[0] & GRP_A_EN}},
                    1'b1};                        // Main has no lock gate

   assign run = ~i_rst_ctl.glbl_rst & (i_rst_ctl.dis_rst_main | i_rst_n);

   always_ff @(posedge i_clk) begin
      o_glbl_rst <= i_rst_ctl.glbl_rst;
      o_rst_n    <= {NUM_RST{run}} & ~i_rst_ctl.sys_rst & grp_ok;
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the clock and reset control testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_clk_ctrl_top -f files.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST PASS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

/* testbench/tb_clk_ctrl_top.sv */
// ====================================================================
// Testbench for the clock and reset control top level
// AXI-Lite driver tasks, stimulus table, value check, cycle timeout
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clk_ctrl_top;
   import clk_rst_pkg::*;

   localparam logic [1:0] OP_WR   = 2'd0;
   localparam logic [1:0] OP_RD   = 2'd1;
   localparam logic [1:0] OP_LOCK = 2'd2;
   localparam logic [1:0] OP_RST  = 2'd3;   // i_rst_n pulse

   typedef struct packed {
      logic [1:0] op;
      csr_addr_t  addr;
      csr_data_t  data;          // Write data or lock vector
      csr_data_t  exp_rdata;
      axi_resp_t  exp_resp;
      rst_vec_t   exp_rst;
      logic       exp_glbl;
      logic       chk_rst;
   } step_t;

   logic        clk;
   logic        rst_n;
   logic [31:0] awaddr;
   logic        awvalid;
   logic        awready;
   csr_data_t   wdata;
   logic        wvalid;
   logic        wready;
   axi_resp_t   bresp;
   logic        bvalid;
   logic        bready;
   logic [31:0] araddr;
   logic        arvalid;
   logic        arready;
   csr_data_t   rdata;
   axi_resp_t   rresp;
   logic        rvalid;
   logic        rready;
   lock_vec_t   mmcm_lock;
   logic        glbl_rst;
   rst_vec_t    dom_rst_n;

   step_t       steps[$];
   step_t       cur;
   csr_data_t   rd_data;
   axi_resp_t   rsp;
   int          errors = 0;
   int          cycles = 0;
   int          limit  = 1000;
   int unsigned seed_ret;

   clk_ctrl_top clk_ctrl_top_inst (
      .i_clk (clk), .i_rst_n (rst_n),
      .i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
      .i_wdata (wdata), .i_wvalid (wvalid), .o_wready (wready),
      .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
      .i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
      .o_rdata (rdata), .o_rresp (rresp), .o_rvalid (rvalid), .i_rready (rready),
      .i_mmcm_lock (mmcm_lock), .o_glbl_rst (glbl_rst), .o_rst_n (dom_rst_n)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;    // 50 MHz
   end

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   // ==================================================================
   // Helper tasks
   // ==================================================================
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         errors = errors + 1;
         $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, expected);
      end
   endtask

   task automatic add_row(input logic [1:0] op, input csr_addr_t addr, input csr_data_t data,
                          input csr_data_t exp_rdata, input axi_resp_t exp_resp,
                          input rst_vec_t exp_rst, input logic exp_glbl, input logic chk);
      step_t s;
      s = '{op, addr, data, exp_rdata, exp_resp, exp_rst, exp_glbl, chk};
      steps.push_back(s);
   endtask

   task automatic axil_write(input csr_addr_t addr, input csr_data_t data,
                             output axi_resp_t resp);
      int unsigned stall;
      stall = $urandom % 4;                 // bready back-pressure
      @(posedge clk);
      awaddr  <= {24'h0, addr};
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      @(posedge clk);                       // AW and W taken here
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      repeat (stall) @(posedge clk);
      @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
      resp = bresp;
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axil_read(input csr_addr_t addr, output csr_data_t data,
                            output axi_resp_t resp);
      int unsigned stall;
      stall = $urandom % 4;
      @(posedge clk);
      araddr  <= {24'h0, addr};
      arvalid <= 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      repeat (stall) @(posedge clk);
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
      data = rdata;
      resp = rresp;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // Four cycles of i_rst_n low with resets checked near the end
   task automatic pulse_reset(input rst_vec_t exp_rst);
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("o_rst_n", {22'h0, dom_rst_n}, {22'h0, exp_rst});
      @(posedge clk);
      rst_n <= 1'b1;
      repeat (6) @(posedge clk);            // Lock sync recovers
   endtask

   // ==================================================================
   // Stimulus table and run
   // ==================================================================
   initial begin
      seed_ret = $urandom(32'h4a0);
      rst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      mmcm_lock = 4'hf;

      // ID words and unmapped address
      add_row(OP_RD, REG_ID,         '0, 32'h5a3c_0001, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD, REG_VER,        '0, 32'h0102_0000, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD, REG_BUILD,      '0, 32'h2024_0611, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD, REG_CLKS_AVAIL, '0, 32'h0000_03ff, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD, 8'h30,          '0, 32'hdead_c0de, 2'b10, 10'h000, 1'b0, 1'b0);
      add_row(OP_WR, 8'h30,          '1, 32'h0,         2'b10, 10'h001, 1'b0, 1'b1);
      add_row(OP_RD, REG_SYS_RST,    '0, 32'hffff_fffe, 2'b00, 10'h001, 1'b0, 1'b1);
      // Per-domain and global reset
      add_row(OP_WR, REG_SYS_RST, 32'h0,   32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_WR, REG_SYS_RST, 32'h155, 32'h0,   2'b00, 10'h2aa, 1'b0, 1'b1);
      add_row(OP_RD, REG_SYS_RST, '0,      32'h155, 2'b00, 10'h2aa, 1'b0, 1'b1);
      add_row(OP_WR, REG_SYS_RST, 32'h0,   32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_WR, REG_G_RST,   '1,      32'h0,   2'b00, 10'h000, 1'b1, 1'b1);
      add_row(OP_RD, REG_G_RST,   '0,      '1,      2'b00, 10'h000, 1'b1, 1'b1);
      add_row(OP_WR, REG_G_RST,   32'h0,   32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      // Lock loss on group B then recovery and error clear
      add_row(OP_LOCK, 8'h00,        32'hd,   32'h0,   2'b00, 10'h3cf, 1'b0, 1'b1);
      add_row(OP_RD,   REG_LOCK,     '0,      32'h141, 2'b00, 10'h3cf, 1'b0, 1'b1);
      add_row(OP_RD,   REG_LOCK_ERR, '0,      32'h010, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_LOCK, 8'h00,        32'hf,   32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_RD,   REG_LOCK,     '0,      32'h151, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD,   REG_LOCK_ERR, '0,      32'h010, 2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_WR,   REG_LOCK_ERR, 32'h010, 32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_RD,   REG_LOCK_ERR, '0,      32'h0,   2'b00, 10'h000, 1'b0, 1'b0);
      // Main reset bypass against i_rst_n pulses
      add_row(OP_WR,  REG_DIS_RST_MAIN, 32'h1,   32'h0,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_RST, 8'h00,            32'h0,   32'h0,   2'b00, 10'h001, 1'b0, 1'b0);
      add_row(OP_RD,  REG_DIS_RST_MAIN, '0,      32'h1,   2'b00, 10'h3ff, 1'b0, 1'b1);
      add_row(OP_WR,  REG_SYS_RST,      32'h200, 32'h0,   2'b00, 10'h1ff, 1'b0, 1'b1);
      add_row(OP_WR,  REG_DIS_RST_MAIN, 32'h0,   32'h0,   2'b00, 10'h1ff, 1'b0, 1'b1);
      add_row(OP_RST, 8'h00,            32'h0,   32'h0,   2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD,  REG_SYS_RST,      '0,      32'h200, 2'b00, 10'h1ff, 1'b0, 1'b1);
      add_row(OP_RD,  REG_LOCK_ERR,     '0,      32'h0,   2'b00, 10'h000, 1'b0, 1'b0);
      add_row(OP_RD,  REG_ID,           '0, 32'h5a3c_0001, 2'b00, 10'h000, 1'b0, 1'b0);

      limit = steps.size() * 40 + 200;

      // Outputs checked while reset is held and just after release
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_value("o_rst_n", {22'h0, dom_rst_n}, 32'h0);
      check_value("o_glbl_rst", {31'h0, glbl_rst}, 32'h0);
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("o_awready", {31'h0, awready}, 32'h0);
      check_value("o_wready", {31'h0, wready}, 32'h0);
      check_value("o_arready", {31'h0, arready}, 32'h0);
      check_value("o_bvalid", {31'h0, bvalid}, 32'h0);
      check_value("o_rvalid", {31'h0, rvalid}, 32'h0);
      repeat (4) @(posedge clk);

      for (int i = 0; i < steps.size(); i++) begin
         cur = steps[i];
         case (cur.op)
            OP_WR: begin
               axil_write(cur.addr, cur.data, rsp);
               check_value("o_bresp", {30'h0, rsp}, {30'h0, cur.exp_resp});
               repeat (4) @(posedge clk);
            end
            OP_RD: begin
               axil_read(cur.addr, rd_data, rsp);
               check_value("o_rdata", rd_data, cur.exp_rdata);
               check_value("o_rresp", {30'h0, rsp}, {30'h0, cur.exp_resp});
               repeat (4) @(posedge clk);
            end
            OP_LOCK: begin
               @(posedge clk);
               mmcm_lock <= cur.data[NUM_MMCM-1:0];
               repeat (4) @(posedge clk);
            end
            default: pulse_reset(cur.exp_rst);
         endcase
         if (cur.chk_rst) begin
            @(negedge clk);
            check_value("o_rst_n", {22'h0, dom_rst_n}, {22'h0, cur.exp_rst});
            check_value("o_glbl_rst", {31'h0, glbl_rst}, {31'h0, cur.exp_glbl});
         end
      end

      $display("Run finished with %0d errors over %0d steps", errors, steps.size());
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
